/* gbcam.f */
+incdir+.
cam_sensor_pkg.sv
cam_buffer_pkg.sv
cam_xck_gen.sv
cam_reg_loader.sv
cam_sensor_seq.sv
cam_pixel_packer.sv
cam_bram_writer.sv
cam_top.sv
tb_cam_top.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the camera testbench with Verilator
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -Wno-fatal -f gbcam.f \
        --top-module tb_cam_top -o sim_tb_cam_top \
    && ./obj_dir/sim_tb_cam_top | tee /dev/stderr | grep -q "^Test OK$" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* tb_cam_top.sv */
`include "gbcam_cfg.svh"

module tb_cam_top;

    import cam_sensor_pkg::*;
    import cam_buffer_pkg::*;

    localparam int     CLK_PERIOD    = 8;
    localparam int     NUM_FRAMES    = 5;
    // xck runs at a quarter of the cart clock toggle rate, 32 sys clocks
    localparam int     XCK_PERIOD    = 32 * CLK_PERIOD;
    localparam int     EXPO_MAX_XCK  = 40 * 8;
    localparam longint WATCHDOG_TIME = longint'(NUM_FRAMES)
        * (`CAM_FRAME_PIXELS + EXPO_MAX_XCK + 400) * XCK_PERIOD;

    logic      sys_clock;
    logic      sys_resetn;
    logic      cam_capture;
    logic      cart_clk;
    cam_reg_t  reg_a000;
    cam_reg_t  reg_a001;
    cam_reg_t  reg_a002;
    cam_reg_t  reg_a003;
    cam_reg_t  reg_a004;
    cam_reg_t  reg_a005;
    logic      sens_xck;
    logic      sens_reset;
    logic      sens_sin;
    logic      sens_load;
    logic      sens_start;
    logic      sens_read;
    cam_pix_t  pix_value;
    logic      bram_req;
    cam_offset_t bram_offset;
    cam_byte_t bram_data;
    logic      bram_done;
    logic      buf_flip;
    logic      block_ready;
    logic      capture_finish;

    logic [31:0] lfsr_state = 32'd68121;
    cam_pix_t    pix_ref [$];
    int          frame_pixels;
    int          rec_count;
    int          frame_writes;
    int          total_writes;
    int          block_count;
    int          word_idx;
    int          sin_count;
    logic [10:0] sin_bits;
    int          expo_edges;
    int          expo_checks;
    logic        expo_counting;
    time         start_time;
    logic        xck_before;

    cam_top dut (.*);

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // one LFSR step per bit taken
    task automatic take_bits(input int n, output logic [7:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[6:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            stop_with_failure($sformatf("FAILED at time %0t: %s, got 0x%0h, expected 0x%0h",
                                        $time, what, actual, expected));
        end
    endtask

    function automatic cam_reg_t gain_p(input logic [2:0] sel);
        case (sel)
            3'd3, 3'd5, 3'd7: return 8'h01;
            default: return 8'h00;
        endcase
    endfunction

    function automatic cam_reg_t gain_m(input logic [2:0] sel);
        case (sel)
            3'd3: return 8'h00;
            3'd5, 3'd7: return 8'h02;
            default: return 8'h01;
        endcase
    endfunction

    // address n in the top three bits, then the register data
    function automatic logic [10:0] expected_word(input int n);
        cam_reg_t data;
        case (n)
            1: data = reg_a001;
            2: data = reg_a002;
            3: data = reg_a003;
            4: data = gain_p(reg_a000[2:0]);
            5: data = gain_m(reg_a000[2:0]);
            6: data = 8'h01;
            7: data = reg_a004;
            default: data = reg_a005;
        endcase
        return {3'(n), data};
    endfunction

    // first pixel lands in the top bits
    function automatic cam_byte_t pack_pixels(input cam_pix_t p0, input cam_pix_t p1,
                                              input cam_pix_t p2, input cam_pix_t p3);
        return {p0, p1, p2, p3};
    endfunction

    task automatic set_frame_regs(input int f);
        logic [7:0] r;
        logic [2:0] pm_sel;
        case (f)
            0: pm_sel = 3'd1;
            1: pm_sel = 3'd3;
            2: pm_sel = 3'd5;
            3: pm_sel = 3'd7;
            default: pm_sel = 3'd2;
        endcase
        take_bits(8, r);
        reg_a000 = {r[7:3], pm_sel};
        take_bits(8, r);
        // short frame on the second capture only
        reg_a001 = (f == 1) ? (r | 8'h80) : (r & 8'h7f);
        reg_a002 = 8'h00;
        take_bits(5, r);
        reg_a003 = 8'h08 + r;
        take_bits(8, r);
        reg_a004 = r;
        take_bits(8, r);
        reg_a005 = r;
        frame_pixels = reg_a001[`CAM_A001_NBIT] ? `CAM_FRAME_PIXELS_NBIT : `CAM_FRAME_PIXELS;
    endtask

    task automatic check_idle_outputs();
        check_value(sens_reset, 1, "sens_reset while idle");
        check_value(sens_sin, 0, "sens_sin while idle");
        check_value(sens_load, 0, "sens_load while idle");
        check_value(sens_start, 0, "sens_start while idle");
        check_value(sens_read, 0, "sens_read while idle");
        check_value(bram_req, 0, "bram_req while idle");
        check_value(buf_flip, 0, "buf_flip while idle");
        check_value(block_ready, 0, "block_ready while idle");
        check_value(capture_finish, 0, "capture_finish while idle");
    endtask

    initial begin
        sys_clock = 1'b0;
        forever #(CLK_PERIOD / 2) sys_clock = !sys_clock;
    end

    initial begin
        cart_clk = 1'b0;
        forever begin
            repeat (8) @(negedge sys_clock);
            cart_clk = !cart_clk;
        end
    end

    // xck toggles once the cart clock rise has passed the synchroniser
    always @(posedge cart_clk) begin
        xck_before = sens_xck;
        repeat (2) @(posedge sys_clock);
        @(negedge sys_clock);
        if (sys_resetn) begin
            check_value(sens_xck, xck_before, "sens_xck held inside the synchroniser");
        end
        @(posedge sys_clock);
        @(negedge sys_clock);
        if (sys_resetn) begin
            check_value(sens_xck, !xck_before, "sens_xck toggle after cart_clk rise");
        end
    end

    // sensor pixel model, new value after each xck fall
    initial begin : drive_pixels
        logic [7:0] v;
        logic       xck_prev;
        pix_value = '0;
        xck_prev  = 1'b0;
        forever begin
            @(negedge sys_clock);
            if (xck_prev && !sens_xck) begin
                take_bits(2, v);
                pix_value = v[1:0];
            end
            xck_prev = sens_xck;
        end
    end

    // RAM model with a random 0 to 3 cycle answer
    initial begin : ram_model
        logic [7:0] v;
        int         ram_wait;
        logic       ram_busy;
        bram_done = 1'b0;
        ram_busy  = 1'b0;
        ram_wait  = 0;
        forever begin
            @(negedge sys_clock);
            if (bram_done) begin
                bram_done = 1'b0;
            end else if (bram_req) begin
                if (!ram_busy) begin
                    ram_busy = 1'b1;
                    take_bits(2, v);
                    ram_wait = v;
                end
                if (ram_wait == 0) begin
                    bram_done = 1'b1;
                    ram_busy  = 1'b0;
                end else begin
                    ram_wait = ram_wait - 1;
                end
            end
        end
    end

    always @(posedge sens_xck) begin
        sin_bits  = {sin_bits[9:0], sens_sin};
        sin_count = sin_count + 1;
        if (expo_counting) begin
            expo_edges = expo_edges + 1;
        end
        if (sens_read && rec_count < frame_pixels) begin
            pix_ref.push_back(pix_value);
            rec_count = rec_count + 1;
        end
    end

    always @(posedge sens_reset) begin
        sin_count = 0;
    end

    // register order 1..7 then 0
    always @(posedge sens_load) begin
        check_value(sin_count, 11, "bits per configuration word");
        check_value(sin_bits, expected_word((word_idx + 1) % 8), "configuration word");
        word_idx  = word_idx + 1;
        sin_count = 0;
    end

    always @(posedge sens_start) begin
        start_time = $time;
    end

    always @(negedge sens_start) begin
        check_value(32'($time - start_time), 2 * 8 * CLK_PERIOD, "sens_start width");
        expo_counting = 1'b1;
        expo_edges    = 0;
    end

    always @(posedge sens_read) begin
        expo_counting = 1'b0;
        check_value(expo_edges >= ({reg_a002, reg_a003} * 8), 1, "exposure length");
        expo_checks = expo_checks + 1;
    end

    // RAM write and block compare
    always @(posedge sys_clock) begin
        if (sys_resetn) begin
            if (block_ready) begin
                block_count = block_count + 1;
                check_value(total_writes % 256, 0, "block_ready position");
            end
            check_value(buf_flip, block_count % 2, "buf_flip against block count");
            if (bram_req && bram_done) begin
                if (pix_ref.size() < 4) begin
                    stop_with_failure("a RAM write came before its four pixels were read");
                end
                check_value(bram_data, pack_pixels(pix_ref[0], pix_ref[1], pix_ref[2],
                                                   pix_ref[3]), "RAM byte");
                check_value(bram_offset, total_writes % 256, "RAM offset");
                repeat (4) void'(pix_ref.pop_front());
                total_writes = total_writes + 1;
                frame_writes = frame_writes + 1;
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_TIME);
        stop_with_failure("the capture did not finish before the watchdog limit");
    end

    initial begin : main_sequence
        int cycles;
        sys_resetn    = 1'b0;
        cam_capture   = 1'b0;
        reg_a000      = '0;
        reg_a001      = '0;
        reg_a002      = '0;
        reg_a003      = '0;
        reg_a004      = '0;
        reg_a005      = '0;
        frame_pixels  = `CAM_FRAME_PIXELS;
        rec_count     = 0;
        frame_writes  = 0;
        total_writes  = 0;
        block_count   = 0;
        word_idx      = 0;
        sin_count     = 0;
        sin_bits      = '0;
        expo_edges    = 0;
        expo_checks   = 0;
        expo_counting = 1'b0;
        start_time    = 0;
        repeat (4) @(posedge sys_clock);
        @(negedge sys_clock);
        sys_resetn = 1'b1;
        check_idle_outputs();
        repeat (50) begin
            @(negedge sys_clock);
            check_idle_outputs();
        end

        for (int f = 0; f < NUM_FRAMES; f++) begin
            set_frame_regs(f);
            rec_count    = 0;
            frame_writes = 0;
            word_idx     = 0;
            expo_checks  = 0;
            cam_capture  = 1'b1;
            cycles       = 0;
            while (capture_finish) begin
                @(negedge sys_clock);
                cycles = cycles + 1;
            end
            check_value(cycles <= 40, 1, "capture_finish cleared at frame start");
            while (!capture_finish) begin
                @(negedge sys_clock);
            end
            cam_capture = 1'b0;

            check_value(word_idx, 8, "configuration words per frame");
            check_value(expo_checks, 1, "exposure phases per frame");
            check_value(rec_count, frame_pixels, "pixels read per frame");
            check_value(frame_writes, frame_pixels / 4, "RAM writes per frame");
            check_value(pix_ref.size(), 0, "pixels left without a RAM write");
            check_value(block_count, total_writes / 256, "blocks completed");
            check_value(bram_req, 0, "RAM request pending at finish");

            // finish holds while the next capture waits
            repeat (50) begin
                @(negedge sys_clock);
                check_value(capture_finish, 1, "capture_finish held");
                check_value(sens_read, 0, "sens_read after finish");
            end
        end

        $display("Test OK");
        $finish;
    end

endmodule

/* cam_top.sv */
module cam_top (
    input  logic                        sys_clock,
    input  logic                        sys_resetn,
    input  logic                        cam_capture,
    input  logic                        cart_clk,
    input  cam_sensor_pkg::cam_reg_t    reg_a000,
    input  cam_sensor_pkg::cam_reg_t    reg_a001,
    input  cam_sensor_pkg::cam_reg_t    reg_a002,
    input  cam_sensor_pkg::cam_reg_t    reg_a003,
    input  cam_sensor_pkg::cam_reg_t    reg_a004,
    input  cam_sensor_pkg::cam_reg_t    reg_a005,
    output logic                        sens_xck,
    output logic                        sens_reset,
    output logic                        sens_sin,
    output logic                        sens_load,
    output logic                        sens_start,
    output logic                        sens_read,
    input  cam_buffer_pkg::cam_pix_t    pix_value,
    output logic                        bram_req,
    output cam_buffer_pkg::cam_offset_t bram_offset,
    output cam_buffer_pkg::cam_byte_t   bram_data,
    input  logic                        bram_done,
    output logic                        buf_flip,
    output logic                        block_ready,
    output logic                        capture_finish
);

    import cam_buffer_pkg::*;

    logic      xck_rise;
    logic      xck_fall;
    logic      clk_fall;
    logic      load_start;
    logic      load_done;
    logic      pix_valid;
    cam_pix_t  pix_data;
    logic      queue_pop;
    logic      queue_empty;
    cam_byte_t queue_data;

    cam_xck_gen u_xck_gen (.*);

    // loader follows the capture level like the sequencer
    cam_reg_loader u_reg_loader (
        .enable (cam_capture),
        .*
    );

    cam_sensor_seq u_sensor_seq (.*);

    cam_pixel_packer u_pixel_packer (.*);

    cam_bram_writer u_bram_writer (.*);

endmodule

/* cam_bram_writer.sv */
`include "gbcam_cfg.svh"

module cam_bram_writer (
    input  logic                        sys_clock,
    input  logic                        sys_resetn,
    input  logic                        queue_empty,
    input  cam_buffer_pkg::cam_byte_t   queue_data,
    input  logic                        bram_done,
    output logic                        queue_pop,
    output logic                        bram_req,
    output cam_buffer_pkg::cam_offset_t bram_offset,
    output cam_buffer_pkg::cam_byte_t   bram_data,
    output logic                        buf_flip,
    output logic                        block_ready
);

    // eight lines of 2-bit pixels per block
    localparam int BLOCK_BYTES = `CAM_LINE_PIXELS * `CAM_BLOCK_LINES / 4;
    localparam int CNT_W       = $clog2(BLOCK_BYTES);

    logic [CNT_W-1:0] byte_cnt;

    assign queue_pop   = !bram_req && !queue_empty;
    assign bram_offset = {2'b00, byte_cnt};

    always_ff @(posedge sys_clock) begin
        if (!sys_resetn) begin
            bram_req    <= 1'b0;
            byte_cnt    <= '0;
            buf_flip    <= 1'b0;
            block_ready <= 1'b0;
        end else begin
            block_ready <= 1'b0;
            if (queue_pop) begin
                bram_req <= 1'b1;
            end else if (bram_req && bram_done) begin
                bram_req <= 1'b0;
                byte_cnt <= byte_cnt + 1'b1;
                // count wraps exactly at the block boundary
                if (byte_cnt == CNT_W'(BLOCK_BYTES - 1)) begin
                    buf_flip    <= !buf_flip;
                    block_ready <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge sys_clock) begin
        if (queue_pop) begin
            bram_data <= queue_data;
        end
    end

    // RAM sees a steady address and byte until it answers
    assert property (@(posedge sys_clock) disable iff (!sys_resetn)
        (bram_req && !bram_done) |=> ($stable(bram_offset) && $stable(bram_data)));

endmodule

/* cam_pixel_packer.sv */
`include "gbcam_cfg.svh"

module cam_pixel_packer (
    input  logic                      sys_clock,
    input  logic                      sys_resetn,
    input  logic                      pix_valid,
    input  cam_buffer_pkg::cam_pix_t  pix_data,
    input  logic                      queue_pop,
    output cam_buffer_pkg::cam_byte_t queue_data,
    output logic                      queue_empty
);

    import cam_buffer_pkg::*;

    localparam logic [`CAM_QUEUE_AW:0] QUEUE_FULL = `CAM_QUEUE_DEPTH;

    logic [5:0]               pix_shift;
    logic [1:0]               pix_cnt;
    logic                     byte_valid;
    cam_byte_t                byte_data;
    cam_byte_t                queue_mem [`CAM_QUEUE_DEPTH];
    logic [`CAM_QUEUE_AW-1:0] wr_ptr;
    logic [`CAM_QUEUE_AW-1:0] rd_ptr;
    logic [`CAM_QUEUE_AW:0]   count;

    // fourth pixel completes the byte
    assign byte_valid = pix_valid && (pix_cnt == 2'd3);
    assign byte_data  = {pix_shift, pix_data};

    always_ff @(posedge sys_clock) begin
        if (!sys_resetn) begin
            pix_cnt <= '0;
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
        end else begin
            if (pix_valid) begin
                pix_cnt <= pix_cnt + 2'd1;
            end
            if (byte_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (queue_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({byte_valid, queue_pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge sys_clock) begin
        if (pix_valid) begin
            pix_shift <= byte_data[5:0];
        end
        if (byte_valid) begin
            queue_mem[wr_ptr] <= byte_data;
        end
    end

    assign queue_data  = queue_mem[rd_ptr];
    assign queue_empty = (count == '0);

    // the RAM side must drain faster than pixels arrive
    assert property (@(posedge sys_clock) disable iff (!sys_resetn)
        byte_valid |-> (count != QUEUE_FULL));

endmodule

/* cam_sensor_seq.sv */
`include "gbcam_cfg.svh"

module cam_sensor_seq (
    input  logic                     sys_clock,
    input  logic                     sys_resetn,
    input  logic                     cam_capture,
    input  logic                     xck_rise,
    input  logic                     xck_fall,
    input  logic                     clk_fall,
    input  logic                     load_done,
    input  logic                     queue_empty,
    input  cam_sensor_pkg::cam_reg_t reg_a001,
    input  cam_sensor_pkg::cam_reg_t reg_a002,
    input  cam_sensor_pkg::cam_reg_t reg_a003,
    input  cam_buffer_pkg::cam_pix_t pix_value,
    output logic                     sens_reset,
    output logic                     sens_start,
    output logic                     sens_read,
    output logic                     load_start,
    output logic                     pix_valid,
    output cam_buffer_pkg::cam_pix_t pix_data,
    output logic                     capture_finish
);

    import cam_sensor_pkg::*;

    localparam int DELAY_W = $clog2(`CAM_SAMPLE_DELAY);

    cam_seq_state_t     state;
    cam_exposure_t      expo_cnt;
    cam_exposure_t      expo_len;
    cam_pixel_idx_t     pix_cnt;
    cam_pixel_idx_t     frame_len;
    logic [2:0]         settle_cnt;
    logic               pulse_sent;
    logic               delay_run;
    logic [DELAY_W-1:0] delay_cnt;
    logic               sample_now;

    assign expo_len  = cam_exposure_t'({reg_a002, reg_a003}) << `CAM_EXPOSURE_SHIFT;
    assign frame_len = reg_a001[`CAM_A001_NBIT] ? cam_pixel_idx_t'(`CAM_FRAME_PIXELS_NBIT)
                                                : cam_pixel_idx_t'(`CAM_FRAME_PIXELS);

    always_ff @(posedge sys_clock) begin
        if (!sys_resetn) begin
            state          <= ST_IDLE;
            expo_cnt       <= '0;
            pix_cnt        <= '0;
            settle_cnt     <= '0;
            pulse_sent     <= 1'b0;
            sens_reset     <= 1'b1;
            sens_start     <= 1'b0;
            sens_read      <= 1'b0;
            load_start     <= 1'b0;
            capture_finish <= 1'b0;
        end else begin
            load_start <= 1'b0;
            if (cam_capture) begin
                case (state)
                    ST_IDLE: begin
                        if (xck_rise) begin
                            capture_finish <= 1'b0;
                            pulse_sent     <= 1'b0;
                            state          <= ST_RESET;
                        end
                    end
                    // reset low for one xck period, changed on the fall
                    ST_RESET, ST_FINAL_RESET: begin
                        if (xck_fall) begin
                            pulse_sent <= 1'b1;
                            sens_reset <= pulse_sent;
                            if (pulse_sent) begin
                                load_start <= (state == ST_RESET);
                                state      <= (state == ST_RESET) ? ST_CONFIG : ST_FINISH;
                            end
                        end
                    end
                    ST_CONFIG: begin
                        if (load_done) begin
                            state <= ST_WAIT;
                        end
                    end
                    ST_WAIT: begin
                        if (xck_rise) begin
                            state <= ST_START;
                        end
                    end
                    // start spans one cart clock period
                    ST_START: begin
                        if (clk_fall) begin
                            sens_start <= !sens_start;
                            if (sens_start) begin
                                expo_cnt <= '0;
                                state    <= ST_EXPOSURE;
                            end
                        end
                    end
                    ST_EXPOSURE: begin
                        if (xck_rise) begin
                            if (expo_cnt == expo_len) begin
                                settle_cnt <= '0;
                                state      <= ST_SETTLE;
                            end else begin
                                expo_cnt <= expo_cnt + 1'b1;
                            end
                        end
                    end
                    ST_SETTLE: begin
                        if (xck_rise) begin
                            settle_cnt <= settle_cnt + 3'd1;
                            if (settle_cnt == 3'(`CAM_SETTLE_XCK - 1)) begin
                                pix_cnt   <= '0;
                                sens_read <= 1'b1;
                                state     <= ST_READ;
                            end
                        end
                    end
                    ST_READ: begin
                        if (xck_rise) begin
                            if (pix_cnt == frame_len) begin
                                sens_read  <= 1'b0;
                                settle_cnt <= '0;
                                state      <= ST_DRAIN;
                            end else begin
                                pix_cnt <= pix_cnt + 1'b1;
                            end
                        end
                    end
                    ST_DRAIN: begin
                        if (xck_rise) begin
                            settle_cnt <= settle_cnt + 3'd1;
                            if (settle_cnt == 3'(2 * `CAM_SETTLE_XCK - 1)) begin
                                pulse_sent <= 1'b0;
                                state      <= ST_FINAL_RESET;
                            end
                        end
                    end
                    ST_FINISH: begin
                        if (queue_empty) begin
                            capture_finish <= 1'b1;
                            state          <= ST_IDLE;
                        end
                    end
                    default: state <= ST_IDLE;
                endcase
            end
        end
    end

    // pixel output settles a few clocks after each read xck rise
    assign sample_now = delay_run && (delay_cnt == DELAY_W'(`CAM_SAMPLE_DELAY - 1));

    always_ff @(posedge sys_clock) begin
        if (!sys_resetn) begin
            delay_run <= 1'b0;
            delay_cnt <= '0;
            pix_valid <= 1'b0;
        end else begin
            pix_valid <= 1'b0;
            if (cam_capture) begin
                if (state == ST_READ && xck_rise && pix_cnt != frame_len) begin
                    delay_run <= 1'b1;
                    delay_cnt <= '0;
                end else if (delay_run) begin
                    delay_cnt <= delay_cnt + 1'b1;
                    if (sample_now) begin
                        delay_run <= 1'b0;
                        pix_valid <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge sys_clock) begin
        if (cam_capture && sample_now) begin
            pix_data <= pix_value;
        end
    end

    // pixels only come out inside the read window
    assert property (@(posedge sys_clock) disable iff (!sys_resetn)
        pix_valid |-> sens_read);

endmodule

/* cam_reg_loader.sv */
`include "gbcam_cfg.svh"

module cam_reg_loader (
    input  logic                     sys_clock,
    input  logic                     sys_resetn,
    input  logic                     enable,
    input  logic                     load_start,
    input  logic                     xck_rise,
    input  logic                     xck_fall,
    input  logic                     clk_fall,
    input  cam_sensor_pkg::cam_reg_t reg_a000,
    input  cam_sensor_pkg::cam_reg_t reg_a001,
    input  cam_sensor_pkg::cam_reg_t reg_a002,
    input  cam_sensor_pkg::cam_reg_t reg_a003,
    input  cam_sensor_pkg::cam_reg_t reg_a004,
    input  cam_sensor_pkg::cam_reg_t reg_a005,
    output logic                     sens_sin,
    output logic                     sens_load,
    output logic                     load_done
);

    import cam_sensor_pkg::*;

    localparam cam_word_t PTR_MSB = cam_word_t'(1) << 10;

    logic       active;
    logic [2:0] reg_idx;
    cam_word_t  bit_ptr;
    cam_word_t  word;
    logic       load_pend;
    logic       last_word;

    // gain fields P and M picked by the A000 mode bits
    function automatic cam_reg_t pm_value(input logic [2:0] sel, input logic want_m);
        cam_reg_t p;
        cam_reg_t m;
        p = 8'h00;
        m = 8'h01;
        if (sel == 3'd3) begin
            p = 8'h01;
            m = 8'h00;
        end else if (sel == 3'd5 || sel == 3'd7) begin
            p = 8'h01;
            m = 8'h02;
        end
        return want_m ? m : p;
    endfunction

    always_comb begin
        case (reg_idx)
            3'd0: word = {3'd0, reg_a005};
            3'd1: word = {3'd1, reg_a001};
            3'd2: word = {3'd2, reg_a002};
            3'd3: word = {3'd3, reg_a003};
            3'd4: word = {3'd4, pm_value(reg_a000[`CAM_A000_PM_SEL], 1'b0)};
            3'd5: word = {3'd5, pm_value(reg_a000[`CAM_A000_PM_SEL], 1'b1)};
            3'd6: word = {3'd6, 8'h01};
            default: word = {3'd7, reg_a004};
        endcase
    end

    // reg_idx wraps back to 1 after register 0, so it is ready for the next run
    always_ff @(posedge sys_clock) begin
        if (!sys_resetn) begin
            active    <= 1'b0;
            reg_idx   <= 3'd1;
            bit_ptr   <= PTR_MSB;
            load_pend <= 1'b0;
            last_word <= 1'b0;
            sens_sin  <= 1'b0;
            sens_load <= 1'b0;
            load_done <= 1'b0;
        end else begin
            load_done <= 1'b0;
            if (enable) begin
                if (load_start) begin
                    active    <= 1'b1;
                    last_word <= 1'b0;
                    sens_sin  <= word[10];
                end else if (active) begin
                    // new bit on xck fall, the sensor takes it on the rise
                    if (xck_fall && !last_word) begin
                        sens_sin <= |(word & bit_ptr);
                    end
                    if (xck_rise && !last_word) begin
                        if (bit_ptr[0]) begin
                            load_pend <= 1'b1;
                            reg_idx   <= reg_idx + 3'd1;
                            bit_ptr   <= PTR_MSB;
                            last_word <= (reg_idx == 3'd0);
                        end else begin
                            bit_ptr <= bit_ptr >> 1;
                        end
                    end
                    if (clk_fall) begin
                        if (load_pend) begin
                            sens_load <= 1'b1;
                            load_pend <= 1'b0;
                        end else if (sens_load) begin
                            sens_load <= 1'b0;
                            if (last_word) begin
                                active    <= 1'b0;
                                load_done <= 1'b1;
                            end
                        end
                    end
                end
            end
        end
    end

    // a load pulse lasts one cart clock period
    assert property (@(posedge sys_clock) disable iff (!sys_resetn)
        (clk_fall && sens_load && enable) |=> !sens_load);

endmodule

/* cam_xck_gen.sv */
module cam_xck_gen (
    input  logic sys_clock,
    input  logic sys_resetn,
    input  logic cart_clk,
    output logic sens_xck,
    output logic xck_rise,
    output logic xck_fall,
    output logic clk_fall
);

    logic [2:0] clk_sync;
    logic       xck_q;

    always_ff @(posedge sys_clock) begin
        if (!sys_resetn) begin
            clk_sync <= 3'b000;
            sens_xck <= 1'b0;
            xck_q    <= 1'b0;
        end else begin
            clk_sync <= {clk_sync[1:0], cart_clk};
            xck_q    <= sens_xck;
            // xck runs at half the cartridge clock
            if (clk_sync[1] && !clk_sync[2]) begin
                sens_xck <= !sens_xck;
            end
        end
    end

    assign clk_fall = clk_sync[2] && !clk_sync[1];
    assign xck_rise = sens_xck && !xck_q;
    assign xck_fall = !sens_xck && xck_q;

endmodule

/* cam_buffer_pkg.sv */
package cam_buffer_pkg;

    // quantized sensor pixel
    typedef logic [1:0] cam_pix_t;
    // four pixels, the first one in the top bits
    typedef logic [7:0] cam_byte_t;
    typedef logic [9:0] cam_offset_t;

endpackage

/* cam_sensor_pkg.sv */
package cam_sensor_pkg;

    // host register byte
    typedef logic [7:0] cam_reg_t;
    // serial word, 3 address bits then 8 data bits
    typedef logic [10:0] cam_word_t;
    typedef logic [14:0] cam_pixel_idx_t;
    // exposure length in xck periods
    typedef logic [18:0] cam_exposure_t;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_RESET,
        ST_CONFIG,
        ST_WAIT,
        ST_START,
        ST_EXPOSURE,
        ST_SETTLE,
        ST_READ,
        ST_DRAIN,
        ST_FINAL_RESET,
        ST_FINISH
    } cam_seq_state_t;

endpackage

/* gbcam_cfg.svh */
`ifndef GBCAM_CFG_SVH
`define GBCAM_CFG_SVH

// frame geometry
`define CAM_LINE_PIXELS       128
`define CAM_FRAME_PIXELS      16384
// two lines fewer when the n bit is set
`define CAM_FRAME_PIXELS_NBIT 16128
`define CAM_BLOCK_LINES       8

// sys clocks from an xck rise to the pixel sample
`define CAM_SAMPLE_DELAY      6

`define CAM_QUEUE_DEPTH       4
`define CAM_QUEUE_AW          2

// exposure registers count in units of 8 xck
`define CAM_EXPOSURE_SHIFT    3
// xck edges before read, doubled before the final reset
`define CAM_SETTLE_XCK        2

// register fields
`define CAM_A001_NBIT         7
`define CAM_A000_PM_SEL       2:0

`endif
